/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	localparam int DRAM_ADDR_W = 21;
	localparam int DATA_W      = 16;
	localparam int ZADDR_W     = 16;
	localparam int PAGE_W      = 8;
	localparam int WIN_COUNT   = 4;
	localparam int BW_W        = 4;

	// word offset inside one 16 KB window
	localparam int WIN_OFS_W = DRAM_ADDR_W - PAGE_W;

	typedef logic [DRAM_ADDR_W-1:0]       dram_addr_t;
	typedef logic [DATA_W-1:0]            dram_data_t;
	typedef logic [ZADDR_W-1:0]           zaddr_t;
	typedef logic [7:0]                   zdata_t;
	typedef logic [PAGE_W-1:0]            page_t;
	typedef logic [$clog2(WIN_COUNT)-1:0] win_idx_t;
	typedef logic [1:0]                   bsel_t;
	typedef logic [BW_W-1:0]              video_bw_t;

	// byte lane selects
	localparam bsel_t BSEL_LO   = 2'b01;
	localparam bsel_t BSEL_HI   = 2'b10;
	localparam bsel_t BSEL_BOTH = 2'b11;

	//////////////////////////////////////////////////
	// dram cycle
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {PH_C0, PH_C1, PH_C2, PH_C3} cycle_phase_t;

	// owner of the current four-phase access
	typedef enum logic [1:0] {SRC_NONE, SRC_VIDEO, SRC_CPU} req_src_t;

endpackage

`default_nettype wire

/* mem_ifs.sv */
`default_nettype none

// cpu side request channel, byte writes via bsel
interface cpu_req_if import mem_pkg::*;
();
	logic       req;
	logic       rnw;
	dram_addr_t addr;
	dram_data_t wrdata;
	bsel_t      bsel;
	logic       next;
	logic       strobe;

	modport requester
	(
		output req, rnw, addr, wrdata, bsel,
		input  next, strobe
	);

	modport arbiter
	(
		input  req, rnw, addr, wrdata, bsel,
		output next, strobe
	);
endinterface

// video side, read only
interface video_req_if import mem_pkg::*;
();
	logic       req;
	dram_addr_t addr;
	logic       next;
	logic       strobe;

	modport requester
	(
		output req, addr,
		input  next, strobe
	);

	modport arbiter
	(
		input  req, addr,
		output next, strobe
	);
endinterface

`default_nettype wire

/* cpu_pager.sv */
`default_nettype none

module cpu_pager import mem_pkg::*;
(
	input  wire        fclk,
	input  wire        rst,

	input  wire        cfg_wr,
	input  win_idx_t   cfg_win,
	input  page_t      cfg_page,
	input  wire        cfg_romnram,

	input  wire        z_req,
	input  wire        z_rnw,
	input  zaddr_t     z_addr,
	input  zdata_t     z_wrdata,
	input  dram_data_t dram_rddata,

	output zdata_t     z_rddata,
	output logic       z_done,
	output logic       rom_cs,

	cpu_req_if.requester mem
);

	typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT, ST_DONE} pager_state_t;

	pager_state_t state;

	page_t page [WIN_COUNT];
	logic  romnram [WIN_COUNT];

	win_idx_t win;

	// latched access
	dram_addr_t req_addr;
	dram_data_t req_wrdata;
	bsel_t      req_bsel;
	logic       req_rnw;
	logic       req_hi;

	//////////////////////////////////////////////////
	// window registers
	//////////////////////////////////////////////////

	// reset maps window i to ram page i
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			for (int i = 0; i < WIN_COUNT; i++)
			begin
				page[i]    <= page_t'(i);
				romnram[i] <= 1'b0;
			end
		end
		else if (cfg_wr)
		begin
			page[cfg_win]    <= cfg_page;
			romnram[cfg_win] <= cfg_romnram;
		end
	end

	assign win = z_addr[ZADDR_W-1:ZADDR_W-2];

	//////////////////////////////////////////////////
	// access fsm
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			state  <= ST_IDLE;
			z_done <= 1'b0;
			rom_cs <= 1'b0;
		end
		else
		begin
			z_done <= 1'b0;
			rom_cs <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (z_req && romnram[win])
					begin
						// rom chip answers on its own, no dram cycle
						z_done <= 1'b1;
						rom_cs <= 1'b1;
						state  <= ST_DONE;
					end
					else if (z_req)
						state <= ST_REQ;
				end
				ST_REQ:
				begin
					if (mem.next)
						state <= ST_WAIT;
				end
				ST_WAIT:
				begin
					if (mem.strobe)
					begin
						z_done <= 1'b1;
						state  <= ST_DONE;
					end
				end
				// z_req is still up here
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge fclk)
	begin
		if (state == ST_IDLE && z_req)
		begin
			req_addr   <= {page[win], z_addr[WIN_OFS_W:1]};
			req_wrdata <= {z_wrdata, z_wrdata};
			req_bsel   <= z_rnw ? BSEL_BOTH : (z_addr[0] ? BSEL_HI : BSEL_LO);
			req_rnw    <= z_rnw;
			req_hi     <= z_addr[0];
		end
		if (state == ST_WAIT && mem.strobe && req_rnw)
			z_rddata <= req_hi ? dram_rddata[15:8] : dram_rddata[7:0];
	end

	assign mem.req    = (state == ST_REQ);
	assign mem.rnw    = req_rnw;
	assign mem.addr   = req_addr;
	assign mem.wrdata = req_wrdata;
	assign mem.bsel   = req_bsel;

	a_req_held: assert property (@(posedge fclk) disable iff (rst)
		mem.req && !mem.next |=> mem.req && $stable(mem.addr) && $stable(mem.rnw));

	a_done_pending: assert property (@(posedge fclk) disable iff (rst)
		z_done |-> z_req);

endmodule

`default_nettype wire

/* video_fetch.sv */
`default_nettype none

module video_fetch import mem_pkg::*;
(
	input  wire        fclk,
	input  wire        rst,

	input  wire        frame_start,
	input  wire        line_start,
	input  page_t      vpage,
	input  video_bw_t  video_bw,
	input  dram_data_t dram_rddata,

	output dram_data_t vid_data,
	output logic       vid_valid,

	video_req_if.requester mem
);

	dram_addr_t vid_addr;
	video_bw_t  burst_cnt;

	//////////////////////////////////////////////////
	// burst counter and address
	//////////////////////////////////////////////////

	// words still to fetch in this line
	always_ff @(posedge fclk)
	begin
		if (rst)
			burst_cnt <= '0;
		else if (line_start)
			burst_cnt <= video_bw;
		else if (mem.next)
			burst_cnt <= burst_cnt - video_bw_t'(1);
	end

	// keeps running over lines, only frame start rewinds it
	always_ff @(posedge fclk)
	begin
		if (frame_start)
			vid_addr <= {vpage, {WIN_OFS_W{1'b0}}};
		else if (mem.next)
			vid_addr <= vid_addr + dram_addr_t'(1);
	end

	assign mem.req  = (burst_cnt != '0);
	assign mem.addr = vid_addr;

	//////////////////////////////////////////////////
	// pixel word out
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
			vid_valid <= 1'b0;
		else
			vid_valid <= mem.strobe;
	end

	always_ff @(posedge fclk)
	begin
		if (mem.strobe)
			vid_data <= dram_rddata;
	end

endmodule

`default_nettype wire

/* dram_arbiter.sv */
`default_nettype none

module dram_arbiter import mem_pkg::*;
(
	input  wire  fclk,
	input  wire  rst,

	cpu_req_if.arbiter   cpu,
	video_req_if.arbiter video,

	output logic       dram_req,
	output logic       dram_rnw,
	output dram_addr_t dram_addr,
	output dram_data_t dram_wrdata,
	output bsel_t      dram_bsel
);

	cycle_phase_t phase;
	req_src_t     owner;
	req_src_t     winner;

	//////////////////////////////////////////////////
	// phase counter, c0..c3 free running
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
			phase <= PH_C0;
		else
			phase <= cycle_phase_t'(phase + 2'd1);
	end

	//////////////////////////////////////////////////
	// selection
	//////////////////////////////////////////////////

	// fixed priority, video first
	always_comb
	begin
		winner = SRC_NONE;
		if (phase == PH_C3)
		begin
			if (video.req)
				winner = SRC_VIDEO;
			else if (cpu.req)
				winner = SRC_CPU;
		end
	end

	assign video.next = (winner == SRC_VIDEO);
	assign cpu.next   = (winner == SRC_CPU);

	// the access granted four cycles ago ends in this c3
	assign video.strobe = (phase == PH_C3) && (owner == SRC_VIDEO);
	assign cpu.strobe   = (phase == PH_C3) && (owner == SRC_CPU);

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			owner    <= SRC_NONE;
			dram_req <= 1'b0;
		end
		else if (phase == PH_C3)
		begin
			owner    <= winner;
			dram_req <= (winner != SRC_NONE);
		end
	end

	//////////////////////////////////////////////////
	// dram port payload
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (phase == PH_C3)
		begin
			case (winner)
				SRC_VIDEO:
				begin
					dram_addr <= video.addr;
					dram_rnw  <= 1'b1;
					dram_bsel <= BSEL_BOTH;
				end
				SRC_CPU:
				begin
					dram_addr   <= cpu.addr;
					dram_rnw    <= cpu.rnw;
					dram_wrdata <= cpu.wrdata;
					dram_bsel   <= cpu.bsel;
				end
				default:
				begin
					// idle cycle, port keeps its last value
				end
			endcase
		end
	end

	a_one_grant: assert property (@(posedge fclk) disable iff (rst)
		!(video.next && cpu.next));

	// a dram access always spans the full four phases
	a_req_on_c3: assert property (@(posedge fclk) disable iff (rst)
		(phase != PH_C3) |=> $stable(dram_req));

endmodule

`default_nettype wire

/* dram_subsys.sv */
`default_nettype none

module dram_subsys import mem_pkg::*;
(
	input  wire        fclk,
	input  wire        rst,

	// window config
	input  wire        cfg_wr,
	input  win_idx_t   cfg_win,
	input  page_t      cfg_page,
	input  wire        cfg_romnram,

	// z80 side
	input  wire        z_req,
	input  wire        z_rnw,
	input  zaddr_t     z_addr,
	input  zdata_t     z_wrdata,
	output zdata_t     z_rddata,
	output wire        z_done,
	output wire        rom_cs,

	// video side
	input  wire        frame_start,
	input  wire        line_start,
	input  page_t      vpage,
	input  video_bw_t  video_bw,
	output dram_data_t vid_data,
	output wire        vid_valid,

	// dram port
	input  dram_data_t dram_rddata,
	output wire        dram_req,
	output wire        dram_rnw,
	output dram_addr_t dram_addr,
	output dram_data_t dram_wrdata,
	output bsel_t      dram_bsel
);

	cpu_req_if   cpu_bus ();
	video_req_if video_bus ();

	cpu_pager cpu_pager_i
	(
		.fclk        (fclk),
		.rst         (rst),
		.cfg_wr      (cfg_wr),
		.cfg_win     (cfg_win),
		.cfg_page    (cfg_page),
		.cfg_romnram (cfg_romnram),
		.z_req       (z_req),
		.z_rnw       (z_rnw),
		.z_addr      (z_addr),
		.z_wrdata    (z_wrdata),
		.dram_rddata (dram_rddata),
		.z_rddata    (z_rddata),
		.z_done      (z_done),
		.rom_cs      (rom_cs),
		.mem         (cpu_bus.requester)
	);

	video_fetch video_fetch_i
	(
		.fclk        (fclk),
		.rst         (rst),
		.frame_start (frame_start),
		.line_start  (line_start),
		.vpage       (vpage),
		.video_bw    (video_bw),
		.dram_rddata (dram_rddata),
		.vid_data    (vid_data),
		.vid_valid   (vid_valid),
		.mem         (video_bus.requester)
	);

	dram_arbiter dram_arbiter_i
	(
		.fclk        (fclk),
		.rst         (rst),
		.cpu         (cpu_bus.arbiter),
		.video       (video_bus.arbiter),
		.dram_req    (dram_req),
		.dram_rnw    (dram_rnw),
		.dram_addr   (dram_addr),
		.dram_wrdata (dram_wrdata),
		.dram_bsel   (dram_bsel)
	);

endmodule

`default_nettype wire

/* tb_dram_model.sv */
`default_nettype none

module tb_dram_model import mem_pkg::*;
(
	input  wire        fclk,
	input  wire        rst,
	input  wire        dram_req,
	input  wire        dram_rnw,
	input  dram_addr_t dram_addr,
	input  dram_data_t dram_wrdata,
	input  bsel_t      dram_bsel,
	output dram_data_t dram_rddata
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WORDS = 2 ** DRAM_ADDR_W;

	dram_data_t mem    [WORDS];
	// expected contents, kept up to date by the testbench
	dram_data_t shadow [WORDS];
	int         seed;
	logic [1:0] phase;

	initial
	begin
		int w;
		seed = 26;
		for (int i = 0; i < WORDS; i++)
		begin
			w = $random(seed);
			mem[dram_addr_t'(i)]    = dram_data_t'(w);
			shadow[dram_addr_t'(i)] = dram_data_t'(w);
		end
	end

	// follows the arbiter phase, both leave reset at c0
	always @(posedge fclk)
	begin
		if (rst)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1;
	end

	// writes land in c3 of the access
	always @(posedge fclk)
	begin
		if (!rst && phase == 2'd3 && dram_req && !dram_rnw)
		begin
			if (dram_bsel[0])
				mem[dram_addr][7:0] = dram_wrdata[7:0];
			if (dram_bsel[1])
				mem[dram_addr][15:8] = dram_wrdata[15:8];
		end
	end

	assign dram_rddata = mem[dram_addr];

endmodule

`default_nettype wire

/* tb_dram_subsys.sv */
`default_nettype none

module tb_dram_subsys import mem_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 8;
	localparam int N_STIM     = 20;

	typedef enum logic [2:0] {K_CFG, K_CPU, K_FRAME, K_LINE, K_PRIO} kind_t;

	typedef struct packed {
		kind_t     kind;
		win_idx_t  win;
		page_t     page;
		logic      romnram;
		logic      rnw;
		zaddr_t    addr;
		zdata_t    wrdata;
		video_bw_t bw;
	} stim_t;

	// prio entries start a video line and a cpu access in the same cycle
	localparam stim_t STIM [N_STIM] = '{
		//  kind     win   page   rom   rnw   addr      wrdata bw
		'{K_CFG,   2'd1, 8'h5a, 1'b0, 1'b0, 16'h0000, 8'h00, 4'd0},
		'{K_CPU,   2'd0, 8'h00, 1'b0, 1'b0, 16'h4001, 8'ha5, 4'd0},
		'{K_CPU,   2'd0, 8'h00, 1'b0, 1'b1, 16'h4001, 8'h00, 4'd0},
		'{K_CPU,   2'd0, 8'h00, 1'b0, 1'b1, 16'h4000, 8'h00, 4'd0},
		'{K_CPU,   2'd0, 8'h00, 1'b0, 1'b0, 16'h4002, 8'h3c, 4'd0},
		'{K_CPU,   2'd0, 8'h00, 1'b0, 1'b1, 16'h4002, 8'h00, 4'd0},
		'{K_CFG,   2'd3, 8'hc3, 1'b0, 1'b0, 16'h0000, 8'h00, 4'd0},
		'{K_CPU,   2'd0, 8'h00, 1'b0, 1'b0, 16'hfffe, 8'h77, 4'd0},
		'{K_CPU,   2'd0, 8'h00, 1'b0, 1'b1, 16'hfffe, 8'h00, 4'd0},
		'{K_CFG,   2'd0, 8'h00, 1'b1, 1'b0, 16'h0000, 8'h00, 4'd0},
		'{K_CPU,   2'd0, 8'h00, 1'b0, 1'b1, 16'h0010, 8'h00, 4'd0},
		'{K_CPU,   2'd0, 8'h00, 1'b0, 1'b0, 16'h0011, 8'h99, 4'd0},
		'{K_FRAME, 2'd0, 8'h5a, 1'b0, 1'b0, 16'h0000, 8'h00, 4'd0},
		'{K_LINE,  2'd0, 8'h00, 1'b0, 1'b0, 16'h0000, 8'h00, 4'd3},
		'{K_LINE,  2'd0, 8'h00, 1'b0, 1'b0, 16'h0000, 8'h00, 4'd2},
		'{K_CFG,   2'd2, 8'h21, 1'b0, 1'b0, 16'h0000, 8'h00, 4'd0},
		'{K_PRIO,  2'd0, 8'h00, 1'b0, 1'b1, 16'h8005, 8'h00, 4'd4},
		'{K_PRIO,  2'd0, 8'h00, 1'b0, 1'b0, 16'h8006, 8'he1, 4'd2},
		'{K_CPU,   2'd0, 8'h00, 1'b0, 1'b1, 16'h8006, 8'h00, 4'd0},
		'{K_CPU,   2'd0, 8'h00, 1'b0, 1'b1, 16'h4001, 8'h00, 4'd0}
	};

	logic       fclk;
	logic       rst;
	logic       cfg_wr;
	win_idx_t   cfg_win;
	page_t      cfg_page;
	logic       cfg_romnram;
	logic       z_req;
	logic       z_rnw;
	zaddr_t     z_addr;
	zdata_t     z_wrdata;
	zdata_t     z_rddata;
	logic       z_done;
	logic       rom_cs;
	logic       frame_start;
	logic       line_start;
	page_t      vpage;
	video_bw_t  video_bw;
	dram_data_t vid_data;
	logic       vid_valid;
	dram_data_t dram_rddata;
	logic       dram_req;
	logic       dram_rnw;
	dram_addr_t dram_addr;
	dram_data_t dram_wrdata;
	bsel_t      dram_bsel;

	// expected window map and video address
	page_t      tb_page [WIN_COUNT];
	logic       tb_rom  [WIN_COUNT];
	dram_addr_t vid_next;

	dram_subsys dram_subsys_i
	(
		.fclk        (fclk),
		.rst         (rst),
		.cfg_wr      (cfg_wr),
		.cfg_win     (cfg_win),
		.cfg_page    (cfg_page),
		.cfg_romnram (cfg_romnram),
		.z_req       (z_req),
		.z_rnw       (z_rnw),
		.z_addr      (z_addr),
		.z_wrdata    (z_wrdata),
		.z_rddata    (z_rddata),
		.z_done      (z_done),
		.rom_cs      (rom_cs),
		.frame_start (frame_start),
		.line_start  (line_start),
		.vpage       (vpage),
		.video_bw    (video_bw),
		.vid_data    (vid_data),
		.vid_valid   (vid_valid),
		.dram_rddata (dram_rddata),
		.dram_req    (dram_req),
		.dram_rnw    (dram_rnw),
		.dram_addr   (dram_addr),
		.dram_wrdata (dram_wrdata),
		.dram_bsel   (dram_bsel)
	);

	tb_dram_model dram_model_i
	(
		.fclk        (fclk),
		.rst         (rst),
		.dram_req    (dram_req),
		.dram_rnw    (dram_rnw),
		.dram_addr   (dram_addr),
		.dram_wrdata (dram_wrdata),
		.dram_bsel   (dram_bsel),
		.dram_rddata (dram_rddata)
	);

	always #(CLK_PERIOD / 2) fclk = ~fclk;

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_byte(input string name, input zdata_t got, input zdata_t exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_word(input string name, input dram_data_t got, input dram_data_t exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input dram_addr_t got, input dram_addr_t exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bsel(input string name, input bsel_t got, input bsel_t exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_quiet();
		check_bit("dram_req", dram_req, 1'b0);
		check_bit("z_done", z_done, 1'b0);
		check_bit("rom_cs", rom_cs, 1'b0);
		check_bit("vid_valid", vid_valid, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// stimulus tasks
	//////////////////////////////////////////////////

	task automatic step();
		@(posedge fclk);
		#1;
	endtask

	task automatic apply_cfg(input win_idx_t win, input page_t page, input logic romnram);
		cfg_wr      = 1'b1;
		cfg_win     = win;
		cfg_page    = page;
		cfg_romnram = romnram;
		step();
		cfg_wr      = 1'b0;
		tb_page[win] = page;
		tb_rom[win]  = romnram;
	endtask

	task automatic start_frame(input page_t page);
		frame_start = 1'b1;
		vpage       = page;
		step();
		frame_start = 1'b0;
		vid_next    = {page, {(DRAM_ADDR_W - PAGE_W){1'b0}}};
	endtask

	// one pixel word against the shadow, addresses run on
	task automatic collect_video(inout int words);
		if (vid_valid)
		begin
			check_word("vid_data", vid_data, dram_model_i.shadow[vid_next]);
			vid_next = vid_next + dram_addr_t'(1);
			words++;
		end
	endtask

	task automatic video_line(input video_bw_t bw);
		int words;
		words      = 0;
		line_start = 1'b1;
		video_bw   = bw;
		while (words < int'(bw))
		begin
			@(negedge fclk);
			collect_video(words);
			if (dram_req)
			begin
				check_bit("dram_rnw", dram_rnw, 1'b1);
				check_addr("dram_addr", dram_addr, vid_next);
			end
			@(posedge fclk);
			#1;
			line_start = 1'b0;
		end
		// no extra words after the burst
		repeat (12)
		begin
			@(negedge fclk);
			check_bit("vid_valid", vid_valid, 1'b0);
		end
	endtask

	task automatic cpu_access(input logic rnw, input zaddr_t addr, input zdata_t wdata,
		input int vid_words);
		win_idx_t   w;
		dram_addr_t a;
		logic       rom;
		logic       done;
		logic       last_req;
		int         cycles;
		int         req_cycles;
		int         words;
		dram_data_t sh;
		w          = addr[ZADDR_W-1:ZADDR_W-2];
		a          = {tb_page[w], addr[13:1]};
		rom        = tb_rom[w];
		done       = 1'b0;
		last_req   = 1'b0;
		cycles     = 0;
		req_cycles = 0;
		words      = 0;
		z_req      = 1'b1;
		z_rnw      = rnw;
		z_addr     = addr;
		z_wrdata   = wdata;
		while (!done)
		begin
			@(negedge fclk);
			cycles++;
			collect_video(words);
			if (rom)
			begin
				// rom answers one cycle after z_req is seen
				check_bit("z_done", z_done, cycles == 2);
				check_bit("rom_cs", rom_cs, cycles == 2);
				check_bit("dram_req", dram_req, 1'b0);
			end
			else
			begin
				check_bit("rom_cs", rom_cs, 1'b0);
				// port checks only while video is idle
				if (dram_req && vid_words == 0)
				begin
					req_cycles++;
					check_addr("dram_addr", dram_addr, a);
					check_bit("dram_rnw", dram_rnw, rnw);
					if (!rnw)
					begin
						check_bsel("dram_bsel", dram_bsel, addr[0] ? 2'b10 : 2'b01);
						check_word("dram_wrdata", dram_wrdata, {wdata, wdata});
					end
				end
			end
			if (z_done)
			begin
				done = 1'b1;
				// z_done follows the last cycle of the cpu access
				if (!rom)
					check_bit("dram_req before z_done", last_req, 1'b1);
				if (!rom && rnw)
				begin
					sh = dram_model_i.shadow[a];
					check_byte("z_rddata", z_rddata, addr[0] ? sh[15:8] : sh[7:0]);
				end
			end
			last_req = dram_req;
			@(posedge fclk);
			#1;
			line_start = 1'b0;
		end
		z_req = 1'b0;
		if (!rom && vid_words == 0 && req_cycles != 4)
			report_failure($sformatf("dram_req was high for %0d cycles of a CPU access, not 4",
				req_cycles));
		if (words != vid_words)
			report_failure($sformatf("%0d video words arrived before z_done, expected %0d",
				words, vid_words));
		if (!rom && !rnw)
		begin
			if (addr[0])
				dram_model_i.shadow[a][15:8] = wdata;
			else
				dram_model_i.shadow[a][7:0] = wdata;
			check_word("dram word", dram_model_i.mem[a], dram_model_i.shadow[a]);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		stim_t      e;
		logic [4:0] n;
		fclk        = 1'b0;
		rst         = 1'b1;
		cfg_wr      = 1'b0;
		cfg_win     = '0;
		cfg_page    = '0;
		cfg_romnram = 1'b0;
		z_req       = 1'b0;
		z_rnw       = 1'b1;
		z_addr      = '0;
		z_wrdata    = '0;
		frame_start = 1'b0;
		line_start  = 1'b0;
		vpage       = '0;
		video_bw    = '0;
		vid_next    = '0;
		for (int i = 0; i < WIN_COUNT; i++)
		begin
			tb_page[i] = page_t'(i);
			tb_rom[i]  = 1'b0;
		end

		// outputs stay low in reset and one cycle after
		for (int i = 0; i < 4; i++)
		begin
			@(posedge fclk);
			#1;
			if (i == 3)
				rst = 1'b0;
			@(negedge fclk);
			check_quiet();
		end
		@(negedge fclk);
		check_quiet();

		for (n = 5'd0; n < 5'(N_STIM); n++)
		begin
			e = STIM[n];
			step();
			case (e.kind)
				K_CFG:   apply_cfg(e.win, e.page, e.romnram);
				K_FRAME: start_frame(e.page);
				K_LINE:  video_line(e.bw);
				K_CPU:   cpu_access(e.rnw, e.addr, e.wrdata, 0);
				K_PRIO:
				begin
					line_start = 1'b1;
					video_bw   = e.bw;
					cpu_access(e.rnw, e.addr, e.wrdata, int'(e.bw));
				end
				default: report_failure("unknown kind in the stimulus table");
			endcase
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

	initial
	begin
		#(N_STIM * 64 * CLK_PERIOD);
		report_failure("run timed out before the stimulus table was done");
	end

endmodule

`default_nettype wire

/* dram_subsys.f */
mem_pkg.sv
mem_ifs.sv
cpu_pager.sv
video_fetch.sv
dram_arbiter.sv
dram_subsys.sv
tb_dram_model.sv
tb_dram_subsys.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_dram_subsys
FILELIST  := dram_subsys.f
OBJ_DIR   := obj_dir

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
PASS_MSG  := *** TEST PASSED ***

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
